// File: verilog.f
+incdir+common
common/avl_bus_pkg.sv
common/avl_bus_if.sv
hdl/fifo_sync.sv
avl_bus_n21/avl_bus_n21_arb.sv
avl_bus_n21/avl_bus_n21.sv
hdl/avl_sram_slave.sv
hdl/avl_subsys_top.sv
dv/tb_clk_gen.sv
dv/avl_subsys_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module avl_subsys_tb -Mdir obj_dir -o avl_subsys_sim > build.log 2>&1 &&
./obj_dir/avl_subsys_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && echo "simulation failed" && exit 1 ||
echo "simulation passed"

// File: dv/avl_subsys_tb.sv
`timescale 1ns/100ps
`include "avl_bus_consts.svh"

module avl_subsys_tb;

  localparam int N_ROWS  = 14;
  localparam int TIMEOUT = 200;
  localparam int MN      = `AVL_MASTER_NUM;

  typedef struct packed {
    logic                   wr;
    logic [`AVL_ADDR_W-1:0] addr;
    logic [`AVL_BE_W-1:0]   be;
    logic [`AVL_DATA_W-1:0] data;
    logic [7:0]             stall;
  } op_t;

  logic                   clk;
  logic                   rst_n;
  logic [`AVL_ADDR_W-1:0] m_address    [MN];
  logic [`AVL_BE_W-1:0]   m_byte_en    [MN];
  logic [MN-1:0]          m_read;
  logic [MN-1:0]          m_write;
  logic [`AVL_DATA_W-1:0] m_write_data [MN];
  logic [MN-1:0]          m_resp_ready;
  logic [MN-1:0]          m_request_ready;
  logic [MN-1:0]          m_read_valid;
  logic [`AVL_DATA_W-1:0] m_read_data  [MN];

  // ********************
  // stimulus table and reference model
  // ********************

  int                     row_test [N_ROWS];
  logic [MN-1:0]          row_en   [N_ROWS];
  op_t                    row_op   [N_ROWS][MN];
  string                  test_name [7];
  logic [`AVL_DATA_W-1:0] ref_mem [2 ** `AVL_ADDR_W];
  logic [`AVL_DATA_W-1:0] exp_data [MN][$];
  int                     exp_stall [MN][$];
  int                     issue_order [$];
  logic [MN-1:0]          issue_done;
  logic [MN-1:0]          served;
  logic                   rr_check;
  logic                   run_aborted;
  int                     n_checks;
  int                     n_errors;
  int                     seed = 32'h3d53_7f3f;

  tb_clk_gen clk_gen_inst (.clk(clk));

  avl_subsys_top avl_subsys_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .m_address      (m_address),
    .m_byte_en      (m_byte_en),
    .m_read         (m_read),
    .m_write        (m_write),
    .m_write_data   (m_write_data),
    .m_resp_ready   (m_resp_ready),
    .m_request_ready(m_request_ready),
    .m_read_valid   (m_read_valid),
    .m_read_data    (m_read_data)
  );

  task automatic put_op(input int r, input int t, input int m, input logic wr,
                        input int addr, input logic [3:0] be,
                        input logic [31:0] data, input int stall);
    row_test[r]  = t;
    row_en[r][m] = 1'b1;
    row_op[r][m] = '{wr: wr, addr: 6'(addr), be: be, data: data, stall: 8'(stall)};
  endtask

  task automatic build_table();
    for (int r = 0; r < N_ROWS; r++) begin
      row_en[r] = '0;
    end
    test_name = '{"", "reset outputs", "write and read back", "byte enables",
                  "round robin", "interleaved reads", "response stall"};
    put_op(0, 2, 0, 1'b1, 5, 4'hf, 32'hcafe_0123, 0);
    put_op(1, 2, 0, 1'b0, 5, 4'hf, 32'h0, 0);
    // a full word, then two partial writes over it.
    put_op(2, 3, 1, 1'b1, 9, 4'hf, 32'h1122_3344, 0);
    put_op(3, 3, 1, 1'b1, 9, 4'h5, 32'haabb_ccdd, 0);
    put_op(4, 3, 1, 1'b1, 9, 4'h8, 32'h5566_7788, 0);
    put_op(5, 3, 1, 1'b0, 9, 4'hf, 32'h0, 0);
    for (int k = 0; k < 3; k++) begin
      for (int m = 0; m < MN; m++) begin
        put_op(6 + k, 4, m, 1'b1, 16 + 4 * k + m, 4'hf, 32'h5a00_0000 + 32'(k * 256 + m), 0);
        // each master reads the word its neighbour wrote.
        put_op(9 + k, 5, m, 1'b0, 16 + 4 * k + (m + 1) % MN, 4'hf, 32'h0, 0);
      end
    end
    for (int k = 0; k < 2; k++) begin
      for (int m = 0; m < MN; m++) begin
        put_op(12 + k, 6, m, 1'b0, 16 + 4 * k + m, 4'hf, 32'h0,
               (m == 2) ? ($random(seed) & 7) + 1 : 0);
      end
    end
  endtask

  // ********************
  // checks
  // ********************

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      n_errors++;
    end
  endtask

  task automatic check_idle_outputs();
    check_value("m_request_ready", 32'(m_request_ready), 32'h0);
    check_value("m_read_valid", 32'(m_read_valid), 32'h0);
  endtask

  task automatic record_accept(input int m, input op_t op);
    if (op.wr) begin
      for (int b = 0; b < `AVL_BE_W; b++) begin
        if (op.be[b]) begin
          ref_mem[op.addr][8*b +: 8] = op.data[8*b +: 8];
        end
      end
    end else begin
      exp_data[m].push_back(ref_mem[op.addr]);
      exp_stall[m].push_back(int'(op.stall));
      issue_order.push_back(m);
    end
    // a round ends once every master has been served.
    if (rr_check) begin
      n_checks++;
      assert (!served[m]) else begin
        $display("ERROR at %0t: master %0d accepted twice in one round", $time, m);
        n_errors++;
      end
      served[m] = 1'b1;
      if (&served) begin
        served = '0;
      end
    end
  endtask

  // ********************
  // master behaviour
  // ********************

  task automatic issue_ops(input int m, input int t);
    op_t op;
    int  cnt;
    @(posedge clk);
    for (int r = 0; r < N_ROWS; r++) begin
      if (row_test[r] == t && row_en[r][m] && !run_aborted) begin
        op = row_op[r][m];
        m_address[m]    <= op.addr;
        m_byte_en[m]    <= op.be;
        m_write_data[m] <= op.data;
        m_write[m]      <= op.wr;
        m_read[m]       <= !op.wr;
        cnt = 0;
        do begin
          @(negedge clk);
          cnt++;
        end while (!m_request_ready[m] && cnt < TIMEOUT);
        assert (m_request_ready[m]) else begin
          $display("ERROR at %0t: master %0d never saw request_ready", $time, m);
          n_errors++;
          run_aborted = 1'b1;
        end
        if (!run_aborted) begin
          record_accept(m, op);
        end
        @(posedge clk);
      end
    end
    m_read[m]     <= 1'b0;
    m_write[m]    <= 1'b0;
    issue_done[m] = 1'b1;
  endtask

  task automatic collect_resps(input int m);
    logic [`AVL_DATA_W-1:0] held;
    int                     cnt;
    cnt = 0;
    while (!(issue_done[m] && exp_data[m].size() == 0) && !run_aborted) begin
      @(negedge clk);
      if (m_read_valid[m]) begin
        n_checks++;
        assert (exp_data[m].size() != 0) else begin
          $display("ERROR at %0t: master %0d got a response it never asked for", $time, m);
          n_errors++;
          run_aborted = 1'b1;
        end
        if (exp_data[m].size() != 0) begin
          held = m_read_data[m];
          for (int s = 0; s < exp_stall[m][0]; s++) begin
            @(negedge clk);
            check_value($sformatf("m_read_valid[%0d]", m), 32'(m_read_valid[m]), 32'h1);
            check_value($sformatf("m_read_data[%0d]", m), m_read_data[m], held);
          end
          @(posedge clk);
          m_resp_ready[m] <= 1'b1;
          @(negedge clk);
          check_value($sformatf("m_read_valid[%0d]", m), 32'(m_read_valid[m]), 32'h1);
          check_value($sformatf("m_read_data[%0d]", m), m_read_data[m], exp_data[m][0]);
          check_value("oldest read owner", 32'(m), 32'(issue_order[0]));
          void'(exp_data[m].pop_front());
          void'(exp_stall[m].pop_front());
          void'(issue_order.pop_front());
          @(posedge clk);
          m_resp_ready[m] <= 1'b0;
          cnt = 0;
        end
      end else if (exp_data[m].size() != 0) begin
        cnt++;
        assert (cnt < TIMEOUT) else begin
          $display("ERROR at %0t: master %0d never saw read_data_valid", $time, m);
          n_errors++;
          run_aborted = 1'b1;
        end
      end
    end
  endtask

  task automatic run_master(input int m, input int t);
    fork
      issue_ops(m, t);
      collect_resps(m);
    join
  endtask

  task automatic report_test(input int t, input int errs_before);
    $display("test %0d %s: %s", t, test_name[t], (n_errors == errs_before) ? "ok" : "failed");
  endtask

  // ********************
  // main sequence
  // ********************

  initial begin
    int errs_before;
    n_checks     = 0;
    n_errors     = 0;
    run_aborted  = 1'b0;
    rr_check     = 1'b0;
    served       = '0;
    issue_done   = '0;
    rst_n        = 1'b0;
    m_read       = '0;
    m_write      = '0;
    m_resp_ready = '0;
    for (int m = 0; m < MN; m++) begin
      m_address[m]    = '0;
      m_byte_en[m]    = '0;
      m_write_data[m] = '0;
    end
    build_table();

    for (int c = 0; c < 16; c++) begin
      @(negedge clk);
      check_idle_outputs();
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_idle_outputs();
    report_test(1, 0);

    for (int t = 2; t <= 6; t++) begin
      if (!run_aborted) begin
        errs_before = n_errors;
        rr_check    = (t == 4);
        served      = '0;
        issue_done  = '0;
        fork
          run_master(0, t);
          run_master(1, t);
          run_master(2, t);
          run_master(3, t);
        join
        report_test(t, errs_before);
      end
    end

    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/100ps

// free-running clock for the testbench.
module tb_clk_gen #(
  parameter real PERIOD = 10.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD / 2.0) clk = ~clk;
    end
  end

endmodule

// File: hdl/avl_subsys_top.sv
`timescale 1ns/100ps
`include "avl_bus_consts.svh"

module avl_subsys_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [`AVL_ADDR_W-1:0]     m_address    [`AVL_MASTER_NUM],
  input  logic [`AVL_BE_W-1:0]       m_byte_en    [`AVL_MASTER_NUM],
  input  logic [`AVL_MASTER_NUM-1:0] m_read,
  input  logic [`AVL_MASTER_NUM-1:0] m_write,
  input  logic [`AVL_DATA_W-1:0]     m_write_data [`AVL_MASTER_NUM],
  input  logic [`AVL_MASTER_NUM-1:0] m_resp_ready,
  output logic [`AVL_MASTER_NUM-1:0] m_request_ready,
  output logic [`AVL_MASTER_NUM-1:0] m_read_valid,
  output logic [`AVL_DATA_W-1:0]     m_read_data  [`AVL_MASTER_NUM]
);

  import avl_bus_pkg::*;

  avl_bus_if m_bus [`AVL_MASTER_NUM] ();
  avl_bus_if s_bus ();

  // ********************
  // master ports
  // ********************

  for (genvar i = 0; i < `AVL_MASTER_NUM; i++) begin : g_master
    assign m_bus[i].address    = m_address[i];
    assign m_bus[i].byte_en    = m_byte_en[i];
    assign m_bus[i].read       = m_read[i];
    assign m_bus[i].write      = m_write[i];
    assign m_bus[i].write_data = m_write_data[i];
    assign m_bus[i].resp_ready = m_resp_ready[i];

    assign m_request_ready[i] = m_bus[i].request_ready;
    assign m_read_valid[i]    = m_bus[i].read_data_valid;
    assign m_read_data[i]     = m_bus[i].read_data;
  end

  // ********************
  // interconnect and slave
  // ********************

  avl_bus_n21 #(
    .ARB_METHOD(arb_round_robin),
    .MASTER_NUM(`AVL_MASTER_NUM)
  ) avl_bus_n21_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .avl_in (m_bus),
    .avl_out(s_bus)
  );

  avl_sram_slave avl_sram_slave_inst (
    .clk  (clk),
    .rst_n(rst_n),
    .bus  (s_bus)
  );

endmodule

// File: hdl/avl_sram_slave.sv
`timescale 1ns/100ps
`include "avl_bus_consts.svh"

// on-chip SRAM behind the bus, one cycle of read latency.
module avl_sram_slave (
  input logic      clk,
  input logic      rst_n,
  avl_bus_if.slave bus
);

  localparam int WORDS = 2 ** `AVL_ADDR_W;

  logic [`AVL_DATA_W-1:0] mem [WORDS];
  logic [`AVL_DATA_W-1:0] resp_data;
  logic                   resp_valid;
  logic                   accept;

  // a new command fits when the response register is free or emptying.
  assign bus.request_ready = !resp_valid || bus.resp_ready;
  assign accept            = bus.request_ready && (bus.read || bus.write);

  assign bus.read_data       = resp_data;
  assign bus.read_data_valid = resp_valid;

  // ********************
  // storage
  // ********************

  // each byte lane is written only when its enable is set.
  always_ff @(posedge clk) begin
    if (accept && bus.write) begin
      for (int b = 0; b < `AVL_BE_W; b++) begin
        if (bus.byte_en[b]) begin
          mem[bus.address][8*b +: 8] <= bus.write_data[8*b +: 8];
        end
      end
    end
  end

  // ********************
  // response register
  // ********************

  always_ff @(posedge clk) begin
    if (accept && bus.read) begin
      resp_data <= mem[bus.address];
    end
  end

  // the response is held until the interconnect takes it.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else if (bus.request_ready) begin
      resp_valid <= accept && bus.read;
    end
  end

  // single-beat commands are either a read or a write, never both.
  a_rd_wr_excl : assert property (@(posedge clk) disable iff (!rst_n)
    !(bus.read && bus.write));

endmodule

// File: avl_bus_n21/avl_bus_n21.sv
`timescale 1ns/100ps
`include "avl_bus_consts.svh"

module avl_bus_n21 #(
  parameter avl_bus_pkg::arb_method_e ARB_METHOD = avl_bus_pkg::arb_round_robin,
  parameter int MASTER_NUM = `AVL_MASTER_NUM
) (
  input  logic      clk,
  input  logic      rst_n,
  avl_bus_if.slave  avl_in [MASTER_NUM],
  avl_bus_if.master avl_out
);

  import avl_bus_pkg::*;

  localparam int SEL_W = (MASTER_NUM > 1) ? $clog2(MASTER_NUM) : 1;

  avl_cmd_t               in_cmd [MASTER_NUM];
  avl_cmd_t               out_cmd;
  logic [MASTER_NUM-1:0]  request;
  logic [MASTER_NUM-1:0]  resp_ready;
  logic [SEL_W-1:0]       sel;
  logic                   accepted;

  logic                   sel_push;
  logic                   sel_pop;
  logic                   sel_full;
  logic                   sel_empty;
  logic [SEL_W-1:0]       sel_head;

  logic                   resp_push;
  logic                   resp_pop;
  logic                   resp_full;
  logic                   resp_empty;
  logic [`AVL_DATA_W-1:0] resp_data;
  logic                   resp_avail;

  // ********************
  // per-master channels
  // ********************

  for (genvar i = 0; i < MASTER_NUM; i++) begin : g_port
    assign in_cmd[i] = '{
      address:    avl_in[i].address,
      byte_en:    avl_in[i].byte_en,
      read:       avl_in[i].read,
      write:      avl_in[i].write,
      write_data: avl_in[i].write_data
    };
    assign request[i]    = avl_in[i].read || avl_in[i].write;
    assign resp_ready[i] = avl_in[i].resp_ready;

    // only the granted master with a live command sees the slave's ready.
    assign avl_in[i].request_ready = (sel == SEL_W'(i)) && request[i] &&
                                     avl_out.request_ready && !sel_full;

    // read data is shared, valid goes only to the owner of the oldest read.
    assign avl_in[i].read_data       = resp_data;
    assign avl_in[i].read_data_valid = (sel_head == SEL_W'(i)) && resp_avail;
  end

  // ********************
  // issue path
  // ********************

  assign out_cmd = in_cmd[sel];

  // with the select FIFO full there is nowhere to record the issuer.
  assign avl_out.address    = out_cmd.address;
  assign avl_out.byte_en    = out_cmd.byte_en;
  assign avl_out.read       = out_cmd.read && !sel_full;
  assign avl_out.write      = out_cmd.write && !sel_full;
  assign avl_out.write_data = out_cmd.write_data;

  assign accepted = avl_out.request_ready && (avl_out.read || avl_out.write);
  assign sel_push = avl_out.request_ready && avl_out.read;

  avl_bus_n21_arb #(
    .ARB_METHOD(ARB_METHOD),
    .MASTER_NUM(MASTER_NUM)
  ) arb_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .request (request),
    .accepted(accepted),
    .sel     (sel)
  );

  // ********************
  // return path
  // ********************

  assign avl_out.resp_ready = !resp_full;
  assign resp_push          = avl_out.read_data_valid && !resp_full;

  // a response is available from storage or from the bypass in this cycle.
  assign resp_avail = !sel_empty && (!resp_empty || resp_push);
  assign resp_pop   = resp_avail && resp_ready[sel_head];
  assign sel_pop    = resp_pop;

  fifo_sync #(
    .DEPTH(`AVL_SEL_FIFO_DEPTH),
    .WIDTH(SEL_W)
  ) sel_fifo_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .write     (sel_push),
    .write_data(sel),
    .full      (sel_full),
    .read      (sel_pop),
    .read_data (sel_head),
    .empty     (sel_empty)
  );

  fifo_sync #(
    .DEPTH(`AVL_RESP_FIFO_DEPTH),
    .WIDTH(`AVL_DATA_W)
  ) resp_fifo_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .write     (resp_push),
    .write_data(avl_out.read_data),
    .full      (resp_full),
    .read      (resp_pop),
    .read_data (resp_data),
    .empty     (resp_empty)
  );

endmodule

// File: avl_bus_n21/avl_bus_n21_arb.sv
`timescale 1ns/100ps

module avl_bus_n21_arb #(
  parameter avl_bus_pkg::arb_method_e ARB_METHOD = avl_bus_pkg::arb_round_robin,
  parameter int MASTER_NUM = 4,
  localparam int SEL_W = (MASTER_NUM > 1) ? $clog2(MASTER_NUM) : 1
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [MASTER_NUM-1:0] request,
  input  logic                  accepted,
  output logic [SEL_W-1:0]      sel
);

  import avl_bus_pkg::*;

  logic [MASTER_NUM-1:0] req_eff;
  logic [SEL_W-1:0]      next_sel;
  logic                  hold;

  // the grant stays put while its master still waits for request_ready.
  assign hold = request[sel] && !accepted;

  // the master just served steps aside so that others get a turn.
  always_comb begin
    req_eff = request;
    if (accepted) begin
      req_eff[sel] = 1'b0;
    end
  end

  // search order: from index 0 for fixed priority, from sel+1 for round robin.
  // the loops run backwards so the first match in search order wins.
  always_comb begin
    int idx;
    next_sel = sel;
    if (ARB_METHOD == arb_fixed_prio) begin
      for (int k = MASTER_NUM - 1; k >= 0; k--) begin
        if (req_eff[k]) begin
          next_sel = SEL_W'(k);
        end
      end
    end else begin
      for (int k = MASTER_NUM; k >= 1; k--) begin
        idx = (int'(sel) + k) % MASTER_NUM;
        if (req_eff[idx]) begin
          next_sel = SEL_W'(idx);
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel <= '0;
    end else if (!hold) begin
      sel <= next_sel;
    end
  end

  // an acceptance always belongs to the live command of the granted master.
  a_accept_granted : assert property (@(posedge clk) disable iff (!rst_n)
    accepted |-> request[sel]);

endmodule

// File: hdl/fifo_sync.sv
`timescale 1ns/100ps

// single clock FIFO. DEPTH must be a power of two.
module fifo_sync #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 8
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             write,
  input  logic [WIDTH-1:0] write_data,
  output logic             full,
  input  logic             read,
  output logic [WIDTH-1:0] read_data,
  output logic             empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW:0]      wr_ptr;
  logic [AW:0]      rd_ptr;
  logic             push;
  logic             pop;

  // the extra pointer bit tells a full FIFO from an empty one.
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // a write into an empty FIFO that is read in the same cycle goes straight
  // through and never lands in storage.
  assign push = write && !(empty && read);
  assign pop  = read && !empty;

  // when empty the incoming word is presented at the output right away.
  assign read_data = empty ? write_data : mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= write_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ********************
  // checks
  // ********************

  // the users gate their writes with full, so an overflow means lost data.
  a_no_overflow : assert property (@(posedge clk) disable iff (!rst_n)
    !(write && full));

  // a read on an empty FIFO is only legal when the bypass supplies the word.
  a_no_underflow : assert property (@(posedge clk) disable iff (!rst_n)
    !(read && empty && !write));

endmodule

// File: common/avl_bus_if.sv
`timescale 1ns/100ps
`include "avl_bus_consts.svh"

// one memory-mapped bus port between a master and a slave.
interface avl_bus_if;

  // command channel.
  logic [`AVL_ADDR_W-1:0] address;
  logic [`AVL_BE_W-1:0]   byte_en;
  logic                   read;
  logic                   write;
  logic [`AVL_DATA_W-1:0] write_data;
  logic                   request_ready;

  // read response channel.
  logic [`AVL_DATA_W-1:0] read_data;
  logic                   read_data_valid;
  logic                   resp_ready;

  modport master (
    output address,
    output byte_en,
    output read,
    output write,
    output write_data,
    output resp_ready,
    input  request_ready,
    input  read_data,
    input  read_data_valid
  );

  modport slave (
    input  address,
    input  byte_en,
    input  read,
    input  write,
    input  write_data,
    input  resp_ready,
    output request_ready,
    output read_data,
    output read_data_valid
  );

endinterface

// File: common/avl_bus_pkg.sv
`include "avl_bus_consts.svh"

package avl_bus_pkg;

  // ********************
  // command of one master
  // ********************

  // one single-beat command as seen on the request side of the bus.
  typedef struct packed {
    logic [`AVL_ADDR_W-1:0] address;
    logic [`AVL_BE_W-1:0]   byte_en;
    logic                   read;
    logic                   write;
    logic [`AVL_DATA_W-1:0] write_data;
  } avl_cmd_t;

  // ********************
  // arbitration
  // ********************

  // round robin rotates after every grant, fixed priority favours index 0.
  typedef enum logic {
    arb_round_robin = 1'b0,
    arb_fixed_prio  = 1'b1
  } arb_method_e;

endpackage

// File: common/avl_bus_consts.svh
`ifndef AVL_BUS_CONSTS_SVH
`define AVL_BUS_CONSTS_SVH

// ********************
// bus geometry
// ********************

// number of masters sharing the single slave port.
`define AVL_MASTER_NUM 4

// word address width, 64 words in the on-chip SRAM.
`define AVL_ADDR_W 6

// data width of one beat.
`define AVL_DATA_W 32

// one byte enable per byte lane.
`define AVL_BE_W (`AVL_DATA_W / 8)

// ********************
// FIFO depths
// ********************

// both depths must be powers of two.
`define AVL_SEL_FIFO_DEPTH 8
`define AVL_RESP_FIFO_DEPTH 4

`endif
